// ==== all.f ====
source/tilegen_pkg.sv
source/video_timing.sv
source/tile_fetch.sv
source/line_buffer.sv
source/pixel_mixer.sv
source/tilegen_top.sv
dv/tilegen_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tilegen_tb
FILELIST = all.f
OBJ_DIR  = obj_dir

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tilegen_tb.sv ====
`timescale 1ns/1ps

module tilegen_tb;

	import tilegen_pkg::*;

	localparam int H_ACTIVE     = 256;
	localparam int H_TOTAL      = 384;
	localparam int H_SYNC_START = 280;
	localparam int H_SYNC_LEN   = 32;
	localparam int V_ACTIVE     = 224;
	localparam int V_TOTAL      = 264;
	localparam int V_SYNC_START = 240;
	localparam int V_SYNC_LEN   = 3;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	// Tests need about 9 frames
	localparam int CYCLE_LIMIT  = 12 * FRAME_CYCLES;

	logic              clk_6m;
	logic              rst;
	logic [CPU_AW-1:0] a;
	logic              we;
	logic [7:0]        md;
	logic              latch0;
	logic              latch1;
	logic              flip;
	logic              backcolor;
	logic [7:0]        r;
	logic [7:0]        g;
	logic [7:0]        b;
	logic              hsync;
	logic              vsync;

	// Reference copies of the map and palette
	logic [15:0] map_ref [MAP_COLS * MAP_ROWS];
	logic [7:0]  pal_ref [256][3];
	// Scroll the model expects on screen
	int          scroll_x;
	int          scroll_y;
	logic [31:0] lcg_state;
	int          cycles = 0;

	tilegen_top #(
		.H_ACTIVE    (H_ACTIVE),
		.H_TOTAL     (H_TOTAL),
		.H_SYNC_START(H_SYNC_START),
		.H_SYNC_LEN  (H_SYNC_LEN),
		.V_ACTIVE    (V_ACTIVE),
		.V_TOTAL     (V_TOTAL),
		.V_SYNC_START(V_SYNC_START),
		.V_SYNC_LEN  (V_SYNC_LEN)
	) tilegen_top_inst (
		.clk_6m   (clk_6m),
		.rst      (rst),
		.a        (a),
		.we       (we),
		.md       (md),
		.latch0   (latch0),
		.latch1   (latch1),
		.flip     (flip),
		.backcolor(backcolor),
		.r        (r),
		.g        (g),
		.b        (b),
		.hsync    (hsync),
		.vsync    (vsync)
	);

	// 8 ns pixel clock
	initial begin
		clk_6m = 1'b0;
		forever #4 clk_6m = ~clk_6m;
	end

	// Watchdog
	always @(posedge clk_6m) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display("Errors found");
			$fatal(1, "watchdog expired");
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [7:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			$display("Errors found");
			$fatal(1, "first mismatch");
		end
	endtask

	// One CPU byte write, called at a falling edge
	task automatic cpu_write(input logic [CPU_AW-1:0] addr, input logic [7:0] data);
		a  = addr;
		md = data;
		we = 1'b1;
		@(negedge clk_6m);
		we = 1'b0;
	endtask

	task automatic latch_scroll(input logic [7:0] sx, input logic [7:0] sy);
		md     = sx;
		latch0 = 1'b1;
		@(negedge clk_6m);
		latch0 = 1'b0;
		md     = sy;
		latch1 = 1'b1;
		@(negedge clk_6m);
		latch1 = 1'b0;
	endtask

	task automatic fill_memories();
		int          i;
		int          c;
		logic [7:0]  d;
		// Map entries, low byte at the even address
		for (i = 0; i < MAP_COLS * MAP_ROWS; i++) begin
			d = next_random();
			map_ref[10'(i)][7:0] = d;
			cpu_write(13'(2 * i), d);
			d = next_random();
			map_ref[10'(i)][15:8] = d;
			cpu_write(13'(2 * i + 1), d);
		end
		// Palette above bit 12, channel in the low bits
		for (i = 0; i < 256; i++) begin
			for (c = 0; c < 3; c++) begin
				d = next_random();
				pal_ref[8'(i)][2'(c)] = d;
				cpu_write(13'(4096 + 4 * i + c), d);
			end
		end
	endtask

	// Screen pixel from the map, pattern rule and palette
	function automatic logic [23:0] expected_rgb(input int x, input int y,
		input logic flip_on, input logic back_on);
		int          mx;
		int          my;
		int          row;
		int          col;
		logic [15:0] entry;
		logic [3:0]  pix;
		logic [7:0]  cidx;
		mx    = ((flip_on ? 255 - x : x) + scroll_x) % 256;
		my    = (y + scroll_y) % 256;
		entry = map_ref[10'((my / TILE_SIZE) * MAP_COLS + mx / TILE_SIZE)];
		row   = my % TILE_SIZE;
		col   = mx % TILE_SIZE;
		pix   = 4'(((int'(entry[3:0]) ^ (row * 2)) + col) % 16);
		cidx  = {entry[15:12], pix};
		// Transparent pixel
		if (pix == 4'd0)
			return back_on ? {pal_ref[0][0], pal_ref[0][1], pal_ref[0][2]} : 24'd0;
		return {pal_ref[cidx][0], pal_ref[cidx][1], pal_ref[cidx][2]};
	endfunction

	// Returns at the falling edge where vsync first reads high
	task automatic wait_vsync_rise();
		logic prev;
		do begin
			prev = vsync;
			@(negedge clk_6m);
		end while (!(vsync && !prev));
	endtask

	// Port-aligned raster starts at hcount 0, vcount V_SYNC_START
	task automatic capture_frame(input string name);
		int x;
		int y;
		int k;
		wait_vsync_rise();
		// Rest of vertical blank
		for (k = 0; k < (V_TOTAL - V_SYNC_START) * H_TOTAL; k++) begin
			check_value($sformatf("%s vblank", name), 32'd0, 32'({r, g, b}));
			@(negedge clk_6m);
		end
		for (y = 0; y < V_ACTIVE; y++) begin
			for (x = 0; x < H_TOTAL; x++) begin
				if (x < H_ACTIVE)
					check_value($sformatf("%s x=%0d y=%0d", name, x, y),
						32'(expected_rgb(x, y, flip, backcolor)), 32'({r, g, b}));
				else
					check_value($sformatf("%s hblank y=%0d", name, y), 32'd0,
						32'({r, g, b}));
				@(negedge clk_6m);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic reset_state();
		rst = 1'b0;
		repeat (5) begin
			@(negedge clk_6m);
			check_value("reset_state rgb", 32'd0, 32'({r, g, b}));
			check_value("reset_state syncs", 32'd0, 32'({hsync, vsync}));
		end
		rst = 1'b1;
		// First edge out of reset
		@(negedge clk_6m);
		check_value("reset_state rgb after", 32'd0, 32'({r, g, b}));
		check_value("reset_state syncs after", 32'd0, 32'({hsync, vsync}));
	endtask

	task automatic unscrolled_frame();
		fill_memories();
		flip      = 1'b0;
		backcolor = 1'b0;
		capture_frame("unscrolled_frame");
	endtask

	task automatic scroll_timing();
		wait_vsync_rise();
		// Middle of the next frame's active area
		repeat ((V_TOTAL - V_SYNC_START + 100) * H_TOTAL) @(negedge clk_6m);
		latch_scroll(8'd13, 8'd77);
		// Copied at the next frame start, shown one frame later
		capture_frame("scroll_timing old");
		scroll_x = 13;
		scroll_y = 77;
		capture_frame("scroll_timing new");
	endtask

	task automatic flip_frame();
		flip = 1'b1;
		capture_frame("flip_frame");
		flip = 1'b0;
	endtask

	task automatic back_colour();
		int         c;
		logic [7:0] d;
		// Fresh entry 0
		for (c = 0; c < 3; c++) begin
			d = next_random();
			pal_ref[0][2'(c)] = d;
			cpu_write(13'(4096 + c), d);
		end
		backcolor = 1'b1;
		capture_frame("back_colour");
	endtask

	task automatic blank_and_sync();
		int   k;
		int   h;
		int   v;
		logic exp_h;
		logic exp_v;
		wait_vsync_rise();
		for (k = 0; k < FRAME_CYCLES; k++) begin
			h     = k % H_TOTAL;
			v     = (V_SYNC_START + k / H_TOTAL) % V_TOTAL;
			exp_h = (h >= H_SYNC_START) && (h < H_SYNC_START + H_SYNC_LEN);
			exp_v = (v >= V_SYNC_START) && (v < V_SYNC_START + V_SYNC_LEN);
			check_value($sformatf("blank_and_sync hsync h=%0d v=%0d", h, v),
				32'(exp_h), 32'(hsync));
			check_value($sformatf("blank_and_sync vsync h=%0d v=%0d", h, v),
				32'(exp_v), 32'(vsync));
			if (h >= H_ACTIVE || v >= V_ACTIVE)
				check_value("blank_and_sync rgb", 32'd0, 32'({r, g, b}));
			@(negedge clk_6m);
		end
		// Next frame's vsync right on time
		check_value("blank_and_sync vsync period", 32'd1, 32'(vsync));
	endtask

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////

	initial begin
		rst       = 1'b0;
		a         = '0;
		we        = 1'b0;
		md        = '0;
		latch0    = 1'b0;
		latch1    = 1'b0;
		flip      = 1'b0;
		backcolor = 1'b0;
		scroll_x  = 0;
		scroll_y  = 0;
		lcg_state = 32'd39462;
		reset_state();
		unscrolled_frame();
		scroll_timing();
		flip_frame();
		back_colour();
		blank_and_sync();
		$display("No errors");
		$finish;
	end

endmodule

// ==== source/tilegen_top.sv ====
`timescale 1ns/1ps

module tilegen_top #(
	parameter int H_ACTIVE     = 256,
	parameter int H_TOTAL      = 384,
	parameter int H_SYNC_START = 280,
	parameter int H_SYNC_LEN   = 32,
	parameter int V_ACTIVE     = 224,
	parameter int V_TOTAL      = 264,
	parameter int V_SYNC_START = 240,
	parameter int V_SYNC_LEN   = 3
) (
	input  logic                            clk_6m,
	input  logic                            rst,
	input  logic [tilegen_pkg::CPU_AW-1:0]  a,
	input  logic                            we,
	input  logic [7:0]                      md,
	input  logic                            latch0,
	input  logic                            latch1,
	input  logic                            flip,
	input  logic                            backcolor,
	output logic [tilegen_pkg::COLOR_W-1:0] r,
	output logic [tilegen_pkg::COLOR_W-1:0] g,
	output logic [tilegen_pkg::COLOR_W-1:0] b,
	output logic                            hsync,
	output logic                            vsync
);

	import tilegen_pkg::*;

	// Raster
	logic [8:0] hcount;
	logic [8:0] vcount;
	logic       line_end;
	logic       frame_start;
	logic       hsync_raw;
	logic       vsync_raw;
	logic       blank_raw;

	// Fetcher to line buffer
	logic              wr_en;
	logic [7:0]        wr_x;
	logic [CIDX_W-1:0] wr_cidx;
	// Line buffer to mixer
	logic [CIDX_W-1:0] rd_cidx;

	//////////////////////////////////////////////////
	// Timing
	//////////////////////////////////////////////////

	video_timing #(
		.H_ACTIVE    (H_ACTIVE),
		.H_TOTAL     (H_TOTAL),
		.H_SYNC_START(H_SYNC_START),
		.H_SYNC_LEN  (H_SYNC_LEN),
		.V_ACTIVE    (V_ACTIVE),
		.V_TOTAL     (V_TOTAL),
		.V_SYNC_START(V_SYNC_START),
		.V_SYNC_LEN  (V_SYNC_LEN)
	) video_timing_inst (
		.clk_6m     (clk_6m),
		.rst        (rst),
		.hcount     (hcount),
		.vcount     (vcount),
		.line_end   (line_end),
		.frame_start(frame_start),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw),
		.blank_raw  (blank_raw)
	);

	//////////////////////////////////////////////////
	// Tile layer pipeline
	//////////////////////////////////////////////////

	tile_fetch #(
		.H_ACTIVE(H_ACTIVE),
		.V_TOTAL (V_TOTAL)
	) tile_fetch_inst (
		.clk_6m     (clk_6m),
		.rst        (rst),
		.hcount     (hcount),
		.vcount     (vcount),
		.frame_start(frame_start),
		.a          (a),
		.we         (we),
		.md         (md),
		.latch0     (latch0),
		.latch1     (latch1),
		.flip       (flip),
		.wr_en      (wr_en),
		.wr_x       (wr_x),
		.wr_cidx    (wr_cidx)
	);

	// Read address follows the raster directly
	line_buffer #(
		.H_ACTIVE(H_ACTIVE)
	) line_buffer_inst (
		.clk_6m  (clk_6m),
		.rst     (rst),
		.line_end(line_end),
		.wr_en   (wr_en),
		.wr_x    (wr_x),
		.wr_cidx (wr_cidx),
		.rd_x    (hcount[7:0]),
		.rd_cidx (rd_cidx)
	);

	pixel_mixer pixel_mixer_inst (
		.clk_6m   (clk_6m),
		.rst      (rst),
		.a        (a),
		.we       (we),
		.md       (md),
		.backcolor(backcolor),
		.rd_cidx  (rd_cidx),
		.hsync_raw(hsync_raw),
		.vsync_raw(vsync_raw),
		.blank_raw(blank_raw),
		.r        (r),
		.g        (g),
		.b        (b),
		.hsync    (hsync),
		.vsync    (vsync)
	);

endmodule

// ==== source/pixel_mixer.sv ====
`timescale 1ns/1ps

module pixel_mixer (
	input  logic                            clk_6m,
	input  logic                            rst,
	input  logic [tilegen_pkg::CPU_AW-1:0]  a,
	input  logic                            we,
	input  logic [7:0]                      md,
	input  logic                            backcolor,
	input  logic [tilegen_pkg::CIDX_W-1:0]  rd_cidx,
	input  logic                            hsync_raw,
	input  logic                            vsync_raw,
	input  logic                            blank_raw,
	output logic [tilegen_pkg::COLOR_W-1:0] r,
	output logic [tilegen_pkg::COLOR_W-1:0] g,
	output logic [tilegen_pkg::COLOR_W-1:0] b,
	output logic                            hsync,
	output logic                            vsync
);

	import tilegen_pkg::*;

	localparam int PAL_DEPTH = 1 << CIDX_W;

	// Palette, one array per channel
	logic [COLOR_W-1:0] pal_r [PAL_DEPTH];
	logic [COLOR_W-1:0] pal_g [PAL_DEPTH];
	logic [COLOR_W-1:0] pal_b [PAL_DEPTH];

	logic              transparent;
	logic              force_black;
	logic [CIDX_W-1:0] pal_idx;

	// First delay stage, lines up with rd_cidx
	logic blank_d1;
	logic hsync_d1;
	logic vsync_d1;

	//////////////////////////////////////////////////
	// CPU side
	//////////////////////////////////////////////////

	// Palette half, channel in the low two bits
	always_ff @(posedge clk_6m) begin
		if (we && a[CPU_AW-1]) begin
			case (a[1:0])
				2'd0: pal_r[a[CIDX_W+1:2]] <= md;
				2'd1: pal_g[a[CIDX_W+1:2]] <= md;
				2'd2: pal_b[a[CIDX_W+1:2]] <= md;
				// Channel 3 ignored
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Colour lookup
	//////////////////////////////////////////////////

	// Pattern pixel 0 is see-through
	assign transparent = (rd_cidx[PIX_W-1:0] == '0);
	// Back colour lives in entry 0
	assign pal_idx     = transparent ? '0 : rd_cidx;
	assign force_black = blank_d1 || (transparent && !backcolor);

	always_ff @(posedge clk_6m) begin
		if (!rst) begin
			r        <= '0;
			g        <= '0;
			b        <= '0;
			hsync_d1 <= 1'b0;
			vsync_d1 <= 1'b0;
			hsync    <= 1'b0;
			vsync    <= 1'b0;
			// Start out blanked
			blank_d1 <= 1'b1;
		end else begin
			// Syncs two cycles behind the counters, like the colour
			hsync_d1 <= hsync_raw;
			vsync_d1 <= vsync_raw;
			hsync    <= hsync_d1;
			vsync    <= vsync_d1;
			blank_d1 <= blank_raw;
			if (force_black) begin
				r <= '0;
				g <= '0;
				b <= '0;
			end else begin
				r <= pal_r[pal_idx];
				g <= pal_g[pal_idx];
				b <= pal_b[pal_idx];
			end
		end
	end

endmodule

// ==== source/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer #(
	parameter int H_ACTIVE = 256
) (
	input  logic                           clk_6m,
	input  logic                           rst,
	input  logic                           line_end,
	input  logic                           wr_en,
	input  logic [7:0]                     wr_x,
	input  logic [tilegen_pkg::CIDX_W-1:0] wr_cidx,
	input  logic [7:0]                     rd_x,
	output logic [tilegen_pkg::CIDX_W-1:0] rd_cidx
);

	import tilegen_pkg::*;

	// Two banks, one line each
	logic [CIDX_W-1:0] bank_mem [2][H_ACTIVE];

	// Front bank number
	logic front;

	//////////////////////////////////////////////////
	// Bank select
	//////////////////////////////////////////////////

	// Swap at the end of every line
	always_ff @(posedge clk_6m) begin
		if (!rst)
			front <= 1'b0;
		else if (line_end)
			front <= ~front;
	end

	//////////////////////////////////////////////////
	// Ports
	//////////////////////////////////////////////////

	// Fetcher fills the back bank
	always_ff @(posedge clk_6m) begin
		if (wr_en)
			bank_mem[~front][wr_x] <= wr_cidx;
	end

	// Display side reads the front bank
	// Data one cycle after rd_x
	always_ff @(posedge clk_6m) begin
		rd_cidx <= bank_mem[front][rd_x];
	end

endmodule

// ==== source/tile_fetch.sv ====
`timescale 1ns/1ps

module tile_fetch #(
	parameter int H_ACTIVE = 256,
	parameter int V_TOTAL  = 264
) (
	input  logic                              clk_6m,
	input  logic                              rst,
	input  logic [8:0]                        hcount,
	input  logic [8:0]                        vcount,
	input  logic                              frame_start,
	input  logic [tilegen_pkg::CPU_AW-1:0]    a,
	input  logic                              we,
	input  logic [7:0]                        md,
	input  logic                              latch0,
	input  logic                              latch1,
	input  logic                              flip,
	output logic                              wr_en,
	output logic [7:0]                        wr_x,
	output logic [tilegen_pkg::CIDX_W-1:0]    wr_cidx
);

	import tilegen_pkg::*;

	localparam int MAP_DEPTH = MAP_COLS * MAP_ROWS;
	localparam int MAP_AW    = $clog2(MAP_DEPTH);

	// Tile map
	tile_entry_t tile_map [MAP_DEPTH];

	// Scroll from CPU, per frame, and for the frame being rendered
	logic [7:0] scroll_x_lat, scroll_y_lat;
	logic [7:0] scroll_x_work, scroll_y_work;
	logic [7:0] scroll_x_cur, scroll_y_cur;

	logic [8:0]        next_line;
	logic              render;
	logic              snap;
	logic [7:0]        scr_x;
	logic [7:0]        map_x;
	logic [7:0]        map_y;
	logic [MAP_AW-1:0] map_idx;

	// Map read stage
	logic                 s1_valid;
	logic [7:0]           s1_x;
	logic [TILE_BITS-1:0] s1_row;
	logic [TILE_BITS-1:0] s1_col;
	tile_entry_t          s1_entry;

	//////////////////////////////////////////////////
	// CPU side
	//////////////////////////////////////////////////

	// Tile map half of the address space, one byte lane per write
	always_ff @(posedge clk_6m) begin
		if (we && !a[CPU_AW-1])
			tile_map[a[MAP_AW:1]].bytes[a[0]] <= md;
	end

	// Snapshot for the new frame, taken on the idle part of the line
	// before line zero gets rendered
	assign snap = (vcount == 9'(V_TOTAL - 2)) && (hcount == 9'(H_ACTIVE));

	always_ff @(posedge clk_6m) begin
		if (!rst) begin
			scroll_x_lat  <= '0;
			scroll_y_lat  <= '0;
			scroll_x_work <= '0;
			scroll_y_work <= '0;
			scroll_x_cur  <= '0;
			scroll_y_cur  <= '0;
		end else begin
			if (latch0)
				scroll_x_lat <= md;
			if (latch1)
				scroll_y_lat <= md;
			if (frame_start) begin
				scroll_x_work <= scroll_x_lat;
				scroll_y_work <= scroll_y_lat;
			end
			if (snap) begin
				scroll_x_cur <= scroll_x_work;
				scroll_y_cur <= scroll_y_work;
			end
		end
	end

	//////////////////////////////////////////////////
	// Address stage
	//////////////////////////////////////////////////

	// Render one line ahead
	assign next_line = (vcount == 9'(V_TOTAL - 1)) ? 9'd0 : vcount + 9'd1;
	assign render    = (hcount < 9'(H_ACTIVE));
	assign scr_x     = hcount[7:0];

	// Mirror first, then scroll, all modulo 256
	assign map_x   = (flip ? ~scr_x : scr_x) + scroll_x_cur;
	assign map_y   = next_line[7:0] + scroll_y_cur;
	// Entry is row times 32 plus column
	assign map_idx = {map_y[7:TILE_BITS], map_x[7:TILE_BITS]};

	// Map read
	always_ff @(posedge clk_6m) begin
		s1_entry <= tile_map[map_idx];
		s1_x     <= scr_x;
		s1_row   <= map_y[TILE_BITS-1:0];
		s1_col   <= map_x[TILE_BITS-1:0];
	end

	//////////////////////////////////////////////////
	// Decode stage
	//////////////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (!rst) begin
			s1_valid <= 1'b0;
			wr_en    <= 1'b0;
		end else begin
			s1_valid <= render;
			wr_en    <= s1_valid;
		end
	end

	// Attribute on top, pattern pixel below
	always_ff @(posedge clk_6m) begin
		wr_x    <= s1_x;
		wr_cidx <= {s1_entry.fields.attr,
			pattern_pixel(s1_entry.fields.code, s1_row, s1_col)};
	end

endmodule

// ==== source/video_timing.sv ====
`timescale 1ns/1ps

module video_timing #(
	parameter int H_ACTIVE     = 256,
	parameter int H_TOTAL      = 384,
	parameter int H_SYNC_START = 280,
	parameter int H_SYNC_LEN   = 32,
	parameter int V_ACTIVE     = 224,
	parameter int V_TOTAL      = 264,
	parameter int V_SYNC_START = 240,
	parameter int V_SYNC_LEN   = 3
) (
	input  logic       clk_6m,
	input  logic       rst,
	output logic [8:0] hcount,
	output logic [8:0] vcount,
	output logic       line_end,
	output logic       frame_start,
	output logic       hsync_raw,
	output logic       vsync_raw,
	output logic       blank_raw
);

	//////////////////////////////////////////////////
	// Raster counters
	//////////////////////////////////////////////////

	// One pixel per clock, never stalls
	always_ff @(posedge clk_6m) begin
		if (!rst) begin
			hcount <= '0;
			vcount <= '0;
		end else if (line_end) begin
			hcount <= '0;
			// Wrap to the top after the last line
			if (vcount == 9'(V_TOTAL - 1))
				vcount <= '0;
			else
				vcount <= vcount + 9'd1;
		end else begin
			hcount <= hcount + 9'd1;
		end
	end

	//////////////////////////////////////////////////
	// Strobes and windows
	//////////////////////////////////////////////////

	// Last pixel clock of every line
	assign line_end    = (hcount == 9'(H_TOTAL - 1));
	// First pixel of line zero
	assign frame_start = (hcount == '0) && (vcount == '0);

	// Syncs active high
	assign hsync_raw = (hcount >= 9'(H_SYNC_START)) &&
		(hcount < 9'(H_SYNC_START + H_SYNC_LEN));
	assign vsync_raw = (vcount >= 9'(V_SYNC_START)) &&
		(vcount < 9'(V_SYNC_START + V_SYNC_LEN));

	// Either blank window
	assign blank_raw = (hcount >= 9'(H_ACTIVE)) || (vcount >= 9'(V_ACTIVE));

endmodule

// ==== source/tilegen_pkg.sv ====
package tilegen_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	// Bits per pattern pixel
	localparam int PIX_W   = 4;
	// Palette bank per tile
	localparam int ATTR_W  = 4;
	// Colour index is attribute then pixel
	localparam int CIDX_W  = 8;
	// Per RGB channel
	localparam int COLOR_W = 8;
	// Tile code field
	localparam int CODE_W  = 12;
	// CPU byte address
	localparam int CPU_AW  = 13;

	//////////////////////////////////////////////////
	// Tile map geometry
	//////////////////////////////////////////////////

	localparam int MAP_COLS  = 32;
	localparam int MAP_ROWS  = 32;
	localparam int TILE_SIZE = 8;
	// Pixel row or column inside one tile
	localparam int TILE_BITS = $clog2(TILE_SIZE);

	// One map entry, written as two bytes and read as fields
	typedef union packed {
		// Low byte sits at the even CPU address
		logic [1:0][7:0] bytes;
		struct packed {
			logic [ATTR_W-1:0] attr;
			logic [CODE_W-1:0] code;
		} fields;
	} tile_entry_t;

	// Pattern table as a fixed rule instead of a ROM
	// Low nibble of code, XOR twice the row, plus the column
	function automatic logic [PIX_W-1:0] pattern_pixel(
		input logic [CODE_W-1:0]    code,
		input logic [TILE_BITS-1:0] row,
		input logic [TILE_BITS-1:0] col
	);
		// Result width wraps the sum modulo 16
		return (code[PIX_W-1:0] ^ (PIX_W'(row) << 1)) + PIX_W'(col);
	endfunction

endpackage
